// ==== src/isa_pkg.sv ====
package isa_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int alu_op_w   = 12;

    typedef logic [alu_op_w-1:0] alu_op_t;

    localparam int alu_add  = 0;  // also address gen and link value
    localparam int alu_sub  = 1;  // beq, bne
    localparam int alu_slt  = 2;
    localparam int alu_sltu = 3;
    localparam int alu_and  = 4;
    localparam int alu_nor  = 5;
    localparam int alu_or   = 6;
    localparam int alu_xor  = 7;
    localparam int alu_sll  = 8;
    localparam int alu_srl  = 9;
    localparam int alu_sra  = 10;
    localparam int alu_lui  = 11;

    localparam logic [xlen-1:0]       link_offset = 32'd4;
    localparam logic [reg_addr_w-1:0] link_reg    = 5'd1;

    // field positions
    localparam int op6_lsb = 26;
    localparam int op4_lsb = 22;
    localparam int op2_lsb = 20;
    localparam int op5_lsb = 15;
    localparam int rd_lsb  = 0;
    localparam int rj_lsb  = 5;
    localparam int rk_lsb  = 10;
    localparam int i12_lsb = 10;  // i16 starts here too
    localparam int i20_lsb = 5;

    localparam logic [5:0] op6_alu       = 6'h00;
    localparam logic [5:0] op6_lu12i     = 6'h05;
    localparam logic [5:0] op6_pcaddu12i = 6'h07;
    localparam logic [5:0] op6_mem       = 6'h0a;

    localparam logic [3:0] op4_3r    = 4'h0;
    localparam logic [3:0] op4_shift = 4'h1;
    localparam logic [3:0] op4_slti  = 4'h8;
    localparam logic [3:0] op4_sltui = 4'h9;
    localparam logic [3:0] op4_addi  = 4'ha;
    localparam logic [3:0] op4_andi  = 4'hd;
    localparam logic [3:0] op4_ori   = 4'he;
    localparam logic [3:0] op4_xori  = 4'hf;

    localparam logic [1:0] op2_3r    = 2'h1;
    localparam logic [1:0] op2_shift = 2'h0;

    // 3r minor opcode per alu index, add through sra
    localparam logic [4:0] op5_3r [alu_sra+1] = '{5'h00, 5'h02, 5'h04, 5'h05, 5'h09, 5'h08,
                                                 5'h0a, 5'h0b, 5'h0e, 5'h0f, 5'h10};
    localparam logic [4:0] op5_shift [3] = '{5'h01, 5'h09, 5'h11};  // slli, srli, srai

    // load/store op4 per mem_op bit, ld_w at bit 0 up to st_b
    localparam logic [3:0] op4_mem [8] = '{4'h2, 4'h9, 4'h1, 4'h8, 4'h0, 4'h6, 4'h5, 4'h4};

    localparam int br_kind_w = 9;
    localparam int br_beq    = 0;
    localparam int br_bne    = 1;
    localparam int br_blt    = 2;
    localparam int br_bge    = 3;
    localparam int br_bltu   = 4;
    localparam int br_bgeu   = 5;
    localparam int br_b      = 6;
    localparam int br_bl     = 7;
    localparam int br_jirl   = 8;

    localparam logic [5:0] op6_br [br_kind_w] = '{6'h16, 6'h17, 6'h18, 6'h19, 6'h1a, 6'h1b,
                                                 6'h14, 6'h15, 6'h13};

endpackage

// ==== src/pipe_pkg.sv ====
package pipe_pkg;

    // one-hot mem kind, st_b at the top down to ld_w at bit 0
    localparam int mem_op_w  = 8;
    localparam int mem_st_b  = 7;
    localparam int mem_st_w  = 5;
    localparam int mem_ld_b  = 4;
    localparam int mem_ld_w  = 0;

    typedef logic [mem_op_w-1:0] mem_op_t;

    localparam int num_rd_ports = 2;
    localparam int port_rj      = 0;
    localparam int port_rkd     = 1;

endpackage

// ==== src/inst_decoder.sv ====
`timescale 1ns/1ps

module inst_decoder (
    input  logic [isa_pkg::xlen-1:0]          inst,
    output isa_pkg::alu_op_t                  alu_op,
    output pipe_pkg::mem_op_t                 mem_op,
    output logic                              res_from_mem,
    output logic                              src1_is_pc,
    output logic                              src2_is_imm,
    output logic [isa_pkg::xlen-1:0]          imm,
    output logic [isa_pkg::reg_addr_w-1:0]    rf_raddr [pipe_pkg::num_rd_ports],
    output logic [pipe_pkg::num_rd_ports-1:0] rd_needed,
    output logic                              gr_we,
    output logic [isa_pkg::reg_addr_w-1:0]    dest,
    output logic [isa_pkg::br_kind_w-1:0]     br_kind,
    output logic [isa_pkg::xlen-1:0]          br_offs,
    output logic                              ine
);

    logic [5:0]  op6;
    logic [3:0]  op4;
    logic [1:0]  op2;
    logic [4:0]  op5;
    logic [isa_pkg::reg_addr_w-1:0] rd;
    logic [isa_pkg::reg_addr_w-1:0] rj;
    logic [isa_pkg::reg_addr_w-1:0] rk;
    logic [11:0] i12;
    logic [15:0] i16;
    logic [19:0] i20;
    logic [25:0] i26;

    logic grp_alu;
    logic is_3r;
    logic is_shift_imm;
    logic is_slti;
    logic is_sltui;
    logic is_addi;
    logic is_andi;
    logic is_ori;
    logic is_xori;
    logic is_ri12;
    logic is_lu12i;
    logic is_pcaddu12i;
    logic is_store;
    logic is_link;
    logic is_cond_br;

    assign op6 = inst[isa_pkg::op6_lsb +: 6];
    assign op4 = inst[isa_pkg::op4_lsb +: 4];
    assign op2 = inst[isa_pkg::op2_lsb +: 2];
    assign op5 = inst[isa_pkg::op5_lsb +: 5];
    assign rd  = inst[isa_pkg::rd_lsb +: isa_pkg::reg_addr_w];
    assign rj  = inst[isa_pkg::rj_lsb +: isa_pkg::reg_addr_w];
    assign rk  = inst[isa_pkg::rk_lsb +: isa_pkg::reg_addr_w];
    assign i12 = inst[isa_pkg::i12_lsb +: 12];
    assign i16 = inst[isa_pkg::i12_lsb +: 16];
    assign i20 = inst[isa_pkg::i20_lsb +: 20];
    assign i26 = {inst[isa_pkg::rd_lsb +: 10], i16};  // offs[25:16] sits in the low bits

    assign grp_alu      = op6 == isa_pkg::op6_alu;
    assign is_3r        = grp_alu && op4 == isa_pkg::op4_3r && op2 == isa_pkg::op2_3r;
    assign is_shift_imm = grp_alu && op4 == isa_pkg::op4_shift && op2 == isa_pkg::op2_shift;
    assign is_slti      = grp_alu && op4 == isa_pkg::op4_slti;
    assign is_sltui     = grp_alu && op4 == isa_pkg::op4_sltui;
    assign is_addi      = grp_alu && op4 == isa_pkg::op4_addi;
    assign is_andi      = grp_alu && op4 == isa_pkg::op4_andi;
    assign is_ori       = grp_alu && op4 == isa_pkg::op4_ori;
    assign is_xori      = grp_alu && op4 == isa_pkg::op4_xori;
    assign is_ri12      = is_slti | is_sltui | is_addi | is_andi | is_ori | is_xori;
    assign is_lu12i     = op6 == isa_pkg::op6_lu12i && !op4[3];
    assign is_pcaddu12i = op6 == isa_pkg::op6_pcaddu12i && !op4[3];

    always_comb begin
        for (int i = 0; i < pipe_pkg::mem_op_w; i++) begin
            mem_op[i] = op6 == isa_pkg::op6_mem && op4 == isa_pkg::op4_mem[i];
        end
        for (int i = 0; i < isa_pkg::br_kind_w; i++) begin
            br_kind[i] = op6 == isa_pkg::op6_br[i];
        end
    end

    assign is_store     = |mem_op[pipe_pkg::mem_st_b:pipe_pkg::mem_st_w];
    assign res_from_mem = |mem_op[pipe_pkg::mem_ld_b:pipe_pkg::mem_ld_w];
    assign is_link      = br_kind[isa_pkg::br_bl] | br_kind[isa_pkg::br_jirl];
    assign is_cond_br   = |br_kind[isa_pkg::br_bgeu:isa_pkg::br_beq];

    always_comb begin
        alu_op = '0;
        for (int i = 0; i <= isa_pkg::alu_sra; i++) begin
            alu_op[i] = is_3r && op5 == isa_pkg::op5_3r[i];
        end
        for (int i = 0; i < 3; i++) begin
            alu_op[isa_pkg::alu_sll + i] |= is_shift_imm && op5 == isa_pkg::op5_shift[i];
        end
        alu_op[isa_pkg::alu_add]  |= is_addi | (|mem_op) | is_link | is_pcaddu12i;
        alu_op[isa_pkg::alu_sub]  |= br_kind[isa_pkg::br_beq] | br_kind[isa_pkg::br_bne];
        alu_op[isa_pkg::alu_slt]  |= is_slti | br_kind[isa_pkg::br_blt] | br_kind[isa_pkg::br_bge];
        alu_op[isa_pkg::alu_sltu] |= is_sltui | br_kind[isa_pkg::br_bltu] |
                                     br_kind[isa_pkg::br_bgeu];
        alu_op[isa_pkg::alu_and]  |= is_andi;
        alu_op[isa_pkg::alu_or]   |= is_ori;
        alu_op[isa_pkg::alu_xor]  |= is_xori;
        alu_op[isa_pkg::alu_lui]   = is_lu12i;
    end

    assign imm = is_link                   ? isa_pkg::link_offset :
                 is_lu12i | is_pcaddu12i   ? {i20, 12'b0} :
                 is_andi | is_ori | is_xori ? {20'b0, i12} :
                                              {{20{i12[11]}}, i12};  // si12, ui5 has bit 11 clear

    assign br_offs = (br_kind[isa_pkg::br_b] | br_kind[isa_pkg::br_bl]) ?
                     {{4{i26[25]}}, i26, 2'b0} : {{14{i16[15]}}, i16, 2'b0};

    assign src1_is_pc  = is_link | is_pcaddu12i;
    assign src2_is_imm = is_ri12 | is_shift_imm | (|mem_op) | is_lu12i | is_pcaddu12i | is_link;

    assign rf_raddr[pipe_pkg::port_rj]  = rj;
    assign rf_raddr[pipe_pkg::port_rkd] = (is_cond_br | is_store) ? rd : rk;
    // jirl reads rj for its target even though src1 is pc
    assign rd_needed[pipe_pkg::port_rj] = is_3r | is_ri12 | is_shift_imm | (|mem_op) |
                                          is_cond_br | br_kind[isa_pkg::br_jirl];
    assign rd_needed[pipe_pkg::port_rkd] = is_3r | is_cond_br | is_store;

    assign gr_we = is_3r | is_ri12 | is_shift_imm | res_from_mem | is_lu12i | is_pcaddu12i |
                   is_link;
    assign dest  = br_kind[isa_pkg::br_bl] ? isa_pkg::link_reg : rd;
    assign ine   = ~(|alu_op | |mem_op | |br_kind);  // b sets only br_kind

endmodule

// ==== src/regfile.sv ====
`timescale 1ns/1ps

module regfile (
    input  logic                           clk,
    input  logic [isa_pkg::reg_addr_w-1:0] raddr1,
    input  logic [isa_pkg::reg_addr_w-1:0] raddr2,
    input  logic                           we,
    input  logic [isa_pkg::reg_addr_w-1:0] waddr,
    input  logic [isa_pkg::xlen-1:0]       wdata,
    output logic [isa_pkg::xlen-1:0]       rdata1,
    output logic [isa_pkg::xlen-1:0]       rdata2
);

    logic [isa_pkg::xlen-1:0] regs [2**isa_pkg::reg_addr_w];

    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // r0 is hardwired
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// ==== src/operand_bypass.sv ====
`timescale 1ns/1ps

module operand_bypass (
    input  logic [isa_pkg::reg_addr_w-1:0] raddr,
    input  logic [isa_pkg::xlen-1:0]       rf_rdata,
    input  logic                           needed,
    input  logic                           es_rf_we,
    input  logic [isa_pkg::reg_addr_w-1:0] es_rf_waddr,
    input  logic [isa_pkg::xlen-1:0]       es_rf_wdata,
    input  logic                           es_res_from_mem,
    input  logic                           ms_rf_we,
    input  logic [isa_pkg::reg_addr_w-1:0] ms_rf_waddr,
    input  logic [isa_pkg::xlen-1:0]       ms_rf_wdata,
    input  logic                           ms_res_from_mem,
    input  logic                           ws_rf_we,
    input  logic [isa_pkg::reg_addr_w-1:0] ws_rf_waddr,
    input  logic [isa_pkg::xlen-1:0]       ws_rf_wdata,
    output logic [isa_pkg::xlen-1:0]       value,
    output logic                           hazard
);

    logic hit_es;
    logic hit_ms;
    logic hit_ws;

    assign hit_es = es_rf_we && raddr != '0 && raddr == es_rf_waddr;
    assign hit_ms = ms_rf_we && raddr != '0 && raddr == ms_rf_waddr;
    assign hit_ws = ws_rf_we && raddr != '0 && raddr == ws_rf_waddr;

    assign value = hit_es ? es_rf_wdata :
                   hit_ms ? ms_rf_wdata :
                   hit_ws ? ws_rf_wdata : rf_rdata;

    // an alu result in es hides an older load in ms
    assign hazard = needed && (hit_es ? es_res_from_mem : hit_ms && ms_res_from_mem);

endmodule

// ==== src/branch_unit.sv ====
`timescale 1ns/1ps

module branch_unit (
    input  logic                          valid,
    input  logic                          stall,
    input  logic [isa_pkg::br_kind_w-1:0] br_kind,
    input  logic [isa_pkg::xlen-1:0]      pc,
    input  logic [isa_pkg::xlen-1:0]      rj_value,
    input  logic [isa_pkg::xlen-1:0]      rkd_value,
    input  logic [isa_pkg::xlen-1:0]      br_offs,
    output logic                          br_taken,
    output logic [isa_pkg::xlen-1:0]      br_target,
    output logic                          br_stall
);

    logic eq;
    logic lt;
    logic ltu;
    logic cond;

    assign eq  = rj_value == rkd_value;
    assign lt  = $signed(rj_value) < $signed(rkd_value);
    assign ltu = rj_value < rkd_value;

    assign cond = br_kind[isa_pkg::br_beq]  &  eq  |
                  br_kind[isa_pkg::br_bne]  & ~eq  |
                  br_kind[isa_pkg::br_blt]  &  lt  |
                  br_kind[isa_pkg::br_bge]  & ~lt  |
                  br_kind[isa_pkg::br_bltu] &  ltu |
                  br_kind[isa_pkg::br_bgeu] & ~ltu |
                  br_kind[isa_pkg::br_b] | br_kind[isa_pkg::br_bl] | br_kind[isa_pkg::br_jirl];

    assign br_taken  = valid && !stall && cond;
    assign br_stall  = valid && stall && |br_kind;  // fetch holds off while operands settle
    assign br_target = (br_kind[isa_pkg::br_jirl] ? rj_value : pc) + br_offs;

endmodule

// ==== src/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage (
    input  logic                           clk,
    input  logic                           resetn,
    input  logic                           fs2ds_valid,
    input  logic [isa_pkg::xlen-1:0]       fs_inst,
    input  logic [isa_pkg::xlen-1:0]       fs_pc,
    input  logic                           es_allowin,
    input  logic                           wb_ex,
    input  logic                           es_rf_we,
    input  logic [isa_pkg::reg_addr_w-1:0] es_rf_waddr,
    input  logic [isa_pkg::xlen-1:0]       es_rf_wdata,
    input  logic                           es_res_from_mem,
    input  logic                           ms_rf_we,
    input  logic [isa_pkg::reg_addr_w-1:0] ms_rf_waddr,
    input  logic [isa_pkg::xlen-1:0]       ms_rf_wdata,
    input  logic                           ms_res_from_mem,
    input  logic                           ws_rf_we,
    input  logic [isa_pkg::reg_addr_w-1:0] ws_rf_waddr,
    input  logic [isa_pkg::xlen-1:0]       ws_rf_wdata,
    output logic                           ds_allowin,
    output logic                           ds2es_valid,
    output logic                           br_stall,
    output logic                           br_taken,
    output logic [isa_pkg::xlen-1:0]       br_target,
    output isa_pkg::alu_op_t               alu_op,
    output logic [isa_pkg::xlen-1:0]       alu_src1,
    output logic [isa_pkg::xlen-1:0]       alu_src2,
    output logic [isa_pkg::xlen-1:0]       rkd_value,
    output logic [isa_pkg::xlen-1:0]       ds_pc,
    output logic                           res_from_mem,
    output pipe_pkg::mem_op_t              mem_op,
    output logic                           rf_we,
    output logic [isa_pkg::reg_addr_w-1:0] rf_waddr,
    output logic                           except_ine
);

    logic                              ds_valid;
    logic [isa_pkg::xlen-1:0]          ds_inst;
    logic                              stall;
    logic                              src1_is_pc;
    logic                              src2_is_imm;
    logic [isa_pkg::xlen-1:0]          imm;
    logic [isa_pkg::reg_addr_w-1:0]    rf_raddr [pipe_pkg::num_rd_ports];
    logic [pipe_pkg::num_rd_ports-1:0] rd_needed;
    logic [pipe_pkg::num_rd_ports-1:0] hazard;
    logic [isa_pkg::xlen-1:0]          rf_rdata [pipe_pkg::num_rd_ports];
    logic [isa_pkg::xlen-1:0]          operand [pipe_pkg::num_rd_ports];
    logic                              gr_we;
    logic [isa_pkg::br_kind_w-1:0]     br_kind;
    logic [isa_pkg::xlen-1:0]          br_offs;

    assign stall       = |hazard;
    assign ds_allowin  = !ds_valid || (!stall && es_allowin);
    assign ds2es_valid = ds_valid && !stall;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ds_valid <= 1'b0;
        end else if (wb_ex || br_taken) begin  // flush beats a taken branch, both just clear
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs2ds_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ds_allowin) begin
            ds_inst <= fs_inst;
            ds_pc   <= fs_pc;
        end
    end

    inst_decoder u_decoder (
        .inst         (ds_inst),
        .alu_op       (alu_op),
        .mem_op       (mem_op),
        .res_from_mem (res_from_mem),
        .src1_is_pc   (src1_is_pc),
        .src2_is_imm  (src2_is_imm),
        .imm          (imm),
        .rf_raddr     (rf_raddr),
        .rd_needed    (rd_needed),
        .gr_we        (gr_we),
        .dest         (rf_waddr),
        .br_kind      (br_kind),
        .br_offs      (br_offs),
        .ine          (except_ine)
    );

    regfile u_regfile (
        .clk    (clk),
        .raddr1 (rf_raddr[pipe_pkg::port_rj]),
        .raddr2 (rf_raddr[pipe_pkg::port_rkd]),
        .we     (ws_rf_we),
        .waddr  (ws_rf_waddr),
        .wdata  (ws_rf_wdata),
        .rdata1 (rf_rdata[pipe_pkg::port_rj]),
        .rdata2 (rf_rdata[pipe_pkg::port_rkd])
    );

    for (genvar p = 0; p < pipe_pkg::num_rd_ports; p++) begin : g_bypass
        operand_bypass u_bypass (
            .raddr           (rf_raddr[p]),
            .rf_rdata        (rf_rdata[p]),
            .needed          (rd_needed[p]),
            .es_rf_we        (es_rf_we),
            .es_rf_waddr     (es_rf_waddr),
            .es_rf_wdata     (es_rf_wdata),
            .es_res_from_mem (es_res_from_mem),
            .ms_rf_we        (ms_rf_we),
            .ms_rf_waddr     (ms_rf_waddr),
            .ms_rf_wdata     (ms_rf_wdata),
            .ms_res_from_mem (ms_res_from_mem),
            .ws_rf_we        (ws_rf_we),
            .ws_rf_waddr     (ws_rf_waddr),
            .ws_rf_wdata     (ws_rf_wdata),
            .value           (operand[p]),
            .hazard          (hazard[p])
        );
    end

    branch_unit u_branch (
        .valid     (ds_valid),
        .stall     (stall),
        .br_kind   (br_kind),
        .pc        (ds_pc),
        .rj_value  (operand[pipe_pkg::port_rj]),
        .rkd_value (operand[pipe_pkg::port_rkd]),
        .br_offs   (br_offs),
        .br_taken  (br_taken),
        .br_target (br_target),
        .br_stall  (br_stall)
    );

    assign alu_src1  = src1_is_pc ? ds_pc : operand[pipe_pkg::port_rj];
    assign alu_src2  = src2_is_imm ? imm : operand[pipe_pkg::port_rkd];
    assign rkd_value = operand[pipe_pkg::port_rkd];  // store data
    assign rf_we     = gr_we && ds_valid;

endmodule

// ==== tb/tb_decode_stage.sv ====
`timescale 1ns/1ps

module tb_decode_stage;

    localparam int wait_limit = 20;

    logic                           clk;
    logic                           resetn;
    logic                           fs2ds_valid;
    logic [isa_pkg::xlen-1:0]       fs_inst;
    logic [isa_pkg::xlen-1:0]       fs_pc;
    logic                           es_allowin;
    logic                           wb_ex;
    logic                           es_rf_we;
    logic [isa_pkg::reg_addr_w-1:0] es_rf_waddr;
    logic [isa_pkg::xlen-1:0]       es_rf_wdata;
    logic                           es_res_from_mem;
    logic                           ms_rf_we;
    logic [isa_pkg::reg_addr_w-1:0] ms_rf_waddr;
    logic [isa_pkg::xlen-1:0]       ms_rf_wdata;
    logic                           ms_res_from_mem;
    logic                           ws_rf_we;
    logic [isa_pkg::reg_addr_w-1:0] ws_rf_waddr;
    logic [isa_pkg::xlen-1:0]       ws_rf_wdata;
    logic                           ds_allowin;
    logic                           ds2es_valid;
    logic                           br_stall;
    logic                           br_taken;
    logic [isa_pkg::xlen-1:0]       br_target;
    isa_pkg::alu_op_t               alu_op;
    logic [isa_pkg::xlen-1:0]       alu_src1;
    logic [isa_pkg::xlen-1:0]       alu_src2;
    logic [isa_pkg::xlen-1:0]       rkd_value;
    logic [isa_pkg::xlen-1:0]       ds_pc;
    logic                           res_from_mem;
    pipe_pkg::mem_op_t              mem_op;
    logic                           rf_we;
    logic [isa_pkg::reg_addr_w-1:0] rf_waddr;
    logic                           except_ine;

    logic [31:0] ref_regs [32];  // shadow of what writeback wrote
    logic [16:0] alu_codes [5] = '{17'h00020, 17'h00022, 17'h00029, 17'h0002e, 17'h00024};
    int          alu_index [5] = '{isa_pkg::alu_add, isa_pkg::alu_sub, isa_pkg::alu_and,
                                   isa_pkg::alu_sll, isa_pkg::alu_slt};
    logic [5:0]  br_codes [4] = '{6'h16, 6'h17, 6'h18, 6'h1b};  // beq bne blt bgeu
    logic [31:0] pc;
    logic [31:0] d_es;
    logic [31:0] d_ms;
    logic [31:0] d_ws;
    logic [11:0] imm12;
    logic [19:0] imm20;
    logic [15:0] offs16;
    logic [25:0] offs26;
    logic        exp_taken;
    int          mismatches;
    int          timeouts;

    decode_stage decode_stage_i (.*);

    always #50 clk = ~clk;

    assert property (@(posedge clk) !resetn |=> !ds2es_valid && !br_taken && !rf_we)
        else begin
            mismatches++;
            $display("%0t: stage not idle right after reset", $time);
        end

    assert property (@(posedge clk) disable iff (!resetn) br_taken |=> !ds2es_valid)
        else begin
            mismatches++;
            $display("%0t: instruction issued the cycle after a taken branch", $time);
        end

    assert property (@(posedge clk) disable iff (!resetn)
                     !es_allowin && ds2es_valid |-> !ds_allowin)
        else begin
            mismatches++;
            $display("%0t: decode accepted while execute was blocked", $time);
        end

    // held instruction must not change while the stage refuses input
    assert property (@(posedge clk) disable iff (!resetn)
                     !ds_allowin |=> $stable(alu_op) && $stable(rf_waddr))
        else begin
            mismatches++;
            $display("%0t: held instruction changed during a stall", $time);
        end

    function automatic logic [31:0] r3_inst(input logic [16:0] op, input logic [4:0] rd,
                                            input logic [4:0] rj, input logic [4:0] rk);
        return {op, rk, rj, rd};
    endfunction

    function automatic logic [31:0] ri12_inst(input logic [9:0] op, input logic [4:0] rd,
                                              input logic [4:0] rj, input logic [11:0] imm);
        return {op, imm, rj, rd};
    endfunction

    function automatic logic [31:0] ri20_inst(input logic [6:0] op, input logic [4:0] rd,
                                              input logic [19:0] imm);
        return {op, imm, rd};
    endfunction

    function automatic logic [31:0] br_inst(input logic [5:0] op, input logic [4:0] rd,
                                            input logic [4:0] rj, input logic [15:0] offs);
        return {op, offs, rj, rd};
    endfunction

    // beq, bne, blt, bgeu in that order
    function automatic logic cond_holds(input int kind, input logic [31:0] a,
                                        input logic [31:0] b);
        case (kind)
            0: return a == b;
            1: return a != b;
            2: return $signed(a) < $signed(b);
            default: return a >= b;
        endcase
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            mismatches++;
            $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #5;
    endtask

    task automatic settle();
        @(negedge clk);
    endtask

    task automatic write_reg(input logic [4:0] addr, input logic [31:0] data);
        ws_rf_we    = 1'b1;
        ws_rf_waddr = addr;
        ws_rf_wdata = data;
        next_cycle();
        ws_rf_we      = 1'b0;
        ref_regs[addr] = data;
    endtask

    // offer one instruction and hold it until decode takes it
    task automatic send(input logic [31:0] inst, input logic [31:0] at_pc);
        int n;
        n           = 0;
        fs2ds_valid = 1'b1;
        fs_inst     = inst;
        fs_pc       = at_pc;
        settle();
        while (!ds_allowin && n < wait_limit) begin
            settle();
            n++;
        end
        if (!ds_allowin) begin
            timeouts++;
            $display("%0t: decode never accepted instruction %h", $time, inst);
        end
        next_cycle();
        fs2ds_valid = 1'b0;
    endtask

    task automatic wait_issue();
        int n;
        n = 0;
        settle();
        while (!ds2es_valid && n < wait_limit) begin
            settle();
            n++;
        end
        if (!ds2es_valid) begin
            timeouts++;
            $display("%0t: stalled instruction never issued", $time);
        end
    endtask

    initial begin
        clk             = 0;
        resetn          = 0;
        fs2ds_valid     = 0;
        fs_inst         = '0;
        fs_pc           = '0;
        es_allowin      = 1;
        wb_ex           = 0;
        es_rf_we        = 0;
        es_rf_waddr     = '0;
        es_rf_wdata     = '0;
        es_res_from_mem = 0;
        ms_rf_we        = 0;
        ms_rf_waddr     = '0;
        ms_rf_wdata     = '0;
        ms_res_from_mem = 0;
        ws_rf_we        = 0;
        ws_rf_waddr     = '0;
        ws_rf_wdata     = '0;
        mismatches      = 0;
        timeouts        = 0;
        void'($urandom(71830));
        repeat (10) @(posedge clk);
        #5;
        resetn = 1;

        for (int i = 0; i < 3; i++) begin
            settle();
            check("ds2es_valid", ds2es_valid, 0);
            check("br_taken", br_taken, 0);
            check("br_stall", br_stall, 0);
            check("rf_we", rf_we, 0);
            next_cycle();
        end

        for (int r = 2; r < 10; r++) begin
            write_reg(r[4:0], $urandom());
        end

        for (int i = 0; i < 5; i++) begin
            pc = $urandom() & 32'hffff_fffc;
            send(r3_inst(alu_codes[i], 5'd10, 5'd2, 5'd3), pc);
            settle();
            check("alu_op", alu_op, 1 << alu_index[i]);
            check("alu_src1", alu_src1, ref_regs[2]);
            check("alu_src2", alu_src2, ref_regs[3]);
            check("rf_waddr", rf_waddr, 10);
            check("rf_we", rf_we, 1);
            check("ds_pc", ds_pc, pc);
            check("except_ine", except_ine, 0);
            next_cycle();
        end
        send(r3_inst(alu_codes[0], 5'd11, 5'd4, 5'd0), 32'h0000_1000);
        settle();
        check("alu_src2", alu_src2, 0);  // r0 reads zero
        next_cycle();

        imm12 = $urandom();
        send(ri12_inst(10'h00a, 5'd12, 5'd2, imm12), 32'h0000_2000);  // addi.w
        settle();
        check("alu_op", alu_op, 1 << isa_pkg::alu_add);
        check("alu_src1", alu_src1, ref_regs[2]);
        check("alu_src2", alu_src2, {{20{imm12[11]}}, imm12});
        next_cycle();
        imm12 = $urandom() | 12'h800;  // top bit set so zero extension shows
        send(ri12_inst(10'h00d, 5'd12, 5'd2, imm12), 32'h0000_2004);  // andi
        settle();
        check("alu_op", alu_op, 1 << isa_pkg::alu_and);
        check("alu_src2", alu_src2, {20'b0, imm12});
        next_cycle();
        imm20 = $urandom();
        send(ri20_inst(7'h0a, 5'd13, imm20), 32'h0000_2008);  // lu12i.w
        settle();
        check("alu_op", alu_op, 1 << isa_pkg::alu_lui);
        check("alu_src2", alu_src2, {imm20, 12'b0});
        next_cycle();
        imm20 = $urandom();
        pc    = $urandom() & 32'hffff_fffc;
        send(ri20_inst(7'h0e, 5'd13, imm20), pc);  // pcaddu12i
        settle();
        check("alu_src1", alu_src1, pc);
        check("alu_src2", alu_src2, {imm20, 12'b0});
        next_cycle();
        imm12 = $urandom();
        send(ri12_inst(10'h0a6, 5'd5, 5'd2, imm12), 32'h0000_2010);  // st.w
        settle();
        check("rf_we", rf_we, 0);
        check("mem_op", mem_op, 8'b0010_0000);
        check("res_from_mem", res_from_mem, 0);
        check("rkd_value", rkd_value, ref_regs[5]);
        check("alu_src2", alu_src2, {{20{imm12[11]}}, imm12});
        next_cycle();
        imm12 = $urandom();
        send(ri12_inst(10'h0a2, 5'd18, 5'd2, imm12), 32'h0000_2014);  // ld.w
        settle();
        check("rf_we", rf_we, 1);
        check("rf_waddr", rf_waddr, 18);
        check("mem_op", mem_op, 8'b0000_0001);
        check("res_from_mem", res_from_mem, 1);
        check("alu_src1", alu_src1, ref_regs[2]);
        check("alu_src2", alu_src2, {{20{imm12[11]}}, imm12});
        next_cycle();

        // forwarding priority with the instruction held by back-pressure
        es_allowin = 0;
        send(r3_inst(alu_codes[0], 5'd14, 5'd6, 5'd7), 32'h0000_3000);
        d_es        = $urandom();
        d_ms        = $urandom();
        d_ws        = $urandom();
        es_rf_we    = 1;
        es_rf_waddr = 6;
        es_rf_wdata = d_es;
        ms_rf_we    = 1;
        ms_rf_waddr = 6;
        ms_rf_wdata = d_ms;
        ws_rf_we    = 1;
        ws_rf_waddr = 6;
        ws_rf_wdata = d_ws;
        settle();
        check("alu_src1", alu_src1, d_es);
        check("alu_src2", alu_src2, ref_regs[7]);
        check("ds_allowin", ds_allowin, 0);
        next_cycle();
        es_rf_we = 0;
        settle();
        check("alu_src1", alu_src1, d_ms);
        next_cycle();
        ms_rf_we = 0;
        settle();
        check("alu_src1", alu_src1, d_ws);
        next_cycle();
        ws_rf_we    = 0;
        ref_regs[6] = d_ws;
        es_allowin  = 1;
        send(r3_inst(alu_codes[0], 5'd15, 5'd0, 5'd7), 32'h0000_3004);
        es_rf_we    = 1;
        es_rf_waddr = 0;
        es_rf_wdata = $urandom() | 1;
        ms_rf_we    = 1;
        ms_rf_waddr = 0;
        ms_rf_wdata = $urandom() | 1;
        ws_rf_we    = 1;
        ws_rf_waddr = 0;
        ws_rf_wdata = $urandom() | 1;
        settle();
        check("alu_src1", alu_src1, 0);
        next_cycle();
        es_rf_we = 0;
        ms_rf_we = 0;
        ws_rf_we = 0;

        // load-use, the load walks es, ms, ws
        send(r3_inst(alu_codes[0], 5'd16, 5'd8, 5'd9), 32'h0000_4000);
        es_rf_we        = 1;
        es_rf_waddr     = 8;
        es_rf_wdata     = $urandom();
        es_res_from_mem = 1;
        settle();
        check("ds2es_valid", ds2es_valid, 0);
        check("ds_allowin", ds_allowin, 0);
        next_cycle();
        es_rf_we        = 0;
        es_res_from_mem = 0;
        ms_rf_we        = 1;
        ms_rf_waddr     = 8;
        ms_rf_wdata     = $urandom();
        ms_res_from_mem = 1;
        settle();
        check("ds2es_valid", ds2es_valid, 0);
        check("rf_waddr", rf_waddr, 16);
        check("alu_src2", alu_src2, ref_regs[9]);
        next_cycle();
        ms_rf_we        = 0;
        ms_res_from_mem = 0;
        d_ws            = $urandom();
        ws_rf_we        = 1;
        ws_rf_waddr     = 8;
        ws_rf_wdata     = d_ws;
        wait_issue();
        check("alu_src1", alu_src1, d_ws);
        next_cycle();
        ws_rf_we    = 0;
        ref_regs[8] = d_ws;

        for (int k = 0; k < 4; k++) begin
            for (int same = 0; same < 2; same++) begin
                pc     = $urandom() & 32'hffff_fffc;
                offs16 = $urandom();
                send(br_inst(br_codes[k], same ? 5'd2 : 5'd3, 5'd2, offs16), pc);
                exp_taken = cond_holds(k, ref_regs[2], ref_regs[same ? 2 : 3]);
                fs2ds_valid = 1;  // offered on the branch edge
                fs_inst     = r3_inst(alu_codes[0], 5'd20, 5'd2, 5'd3);
                settle();
                check("br_taken", br_taken, exp_taken);
                check("br_target", br_target, pc + {{14{offs16[15]}}, offs16, 2'b0});
                next_cycle();
                fs2ds_valid = 0;
                settle();
                check("ds2es_valid", ds2es_valid, !exp_taken);
                next_cycle();
            end
        end

        offs16 = $urandom();
        send(br_inst(6'h13, 5'd17, 5'd4, offs16), 32'h0000_5000);  // jirl
        settle();
        check("br_taken", br_taken, 1);
        check("br_target", br_target, ref_regs[4] + {{14{offs16[15]}}, offs16, 2'b0});
        check("rf_waddr", rf_waddr, 17);
        next_cycle();
        offs26 = $urandom();
        pc     = $urandom() & 32'hffff_fffc;
        send({6'h15, offs26[15:0], offs26[25:16]}, pc);  // bl
        settle();
        check("rf_waddr", rf_waddr, 1);
        check("alu_src1", alu_src1, pc);
        check("alu_src2", alu_src2, 4);
        check("br_target", br_target, pc + {{4{offs26[25]}}, offs26, 2'b0});
        next_cycle();

        // beq waits on a load in es
        offs16 = $urandom();
        pc     = $urandom() & 32'hffff_fffc;
        send(br_inst(6'h16, 5'd2, 5'd2, offs16), pc);
        es_rf_we        = 1;
        es_rf_waddr     = 2;
        es_rf_wdata     = $urandom();
        es_res_from_mem = 1;
        settle();
        check("br_stall", br_stall, 1);
        check("br_taken", br_taken, 0);
        check("ds_pc", ds_pc, pc);
        next_cycle();
        es_rf_we        = 0;
        es_res_from_mem = 0;
        settle();
        check("br_stall", br_stall, 0);
        check("br_taken", br_taken, 1);
        check("br_target", br_target, pc + {{14{offs16[15]}}, offs16, 2'b0});
        next_cycle();

        send(32'hffff_ffff, 32'h0000_6000);
        settle();
        check("except_ine", except_ine, 1);
        next_cycle();
        repeat (2) next_cycle();

        $display("failed checks %0d, timeouts %0d", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== all.f ====
src/isa_pkg.sv
src/pipe_pkg.sv
src/inst_decoder.sv
src/regfile.sv
src/operand_bypass.sv
src/branch_unit.sv
src/decode_stage.sv
tb/tb_decode_stage.sv

// ==== Bender.yml ====
package:
  name: decode_stage

sources:
  - src/isa_pkg.sv
  - src/pipe_pkg.sv
  - src/inst_decoder.sv
  - src/regfile.sv
  - src/operand_bypass.sv
  - src/branch_unit.sv
  - src/decode_stage.sv
  - target: test
    files:
      - tb/tb_decode_stage.sv
